//--- sources.f
+incdir+.
eg_pkg.sv
eg_apb_regs.sv
eg_rate_gen.sv
eg_rate_calc.sv
eg_level_core.sv
eg_atten_post.sv
eg_top.sv
eg_tb.sv

//--- eg_tb_model.svh
`ifndef EG_TB_MODEL_SVH
`define EG_TB_MODEL_SVH

////////////////////
// shadow of the bank

logic [31:0] shadow_w0 [`EG_NUM_SLOTS];   // kon ks kcode ar
logic [31:0] shadow_w1 [`EG_NUM_SLOTS];   // d1r d2r rr d1l tl ams
logic [31:0] shadow_glob;                 // lfa test_d0 test_d5

// slot words below 0x100, global word at 0x100
function automatic logic addr_in_map(input logic [11:0] addr);
    return (addr == `EG_GLOBAL_ADDR) || ((addr < 12'h100) && (addr[1:0] == 2'b00));
endfunction

function automatic logic [31:0] word_mask(input logic [11:0] addr);
    if (addr == `EG_GLOBAL_ADDR) begin
        return 32'h0000_03ff;
    end
    return addr[2] ? 32'h07ff_ffff : 32'h0000_1fff;   // word 1 : word 0
endfunction

function automatic void shadow_store(input logic [11:0] addr, input logic [31:0] data);
    if (addr == `EG_GLOBAL_ADDR) begin
        shadow_glob = data & word_mask(addr);
    end else if (addr_in_map(addr) && addr[2]) begin
        shadow_w1[addr[7:3]] = data & word_mask(addr);
    end else if (addr_in_map(addr)) begin
        shadow_w0[addr[7:3]] = data & word_mask(addr);
    end
endfunction

function automatic logic [31:0] shadow_read(input logic [11:0] addr);
    if (addr == `EG_GLOBAL_ADDR) begin
        return shadow_glob;
    end
    return addr[2] ? shadow_w1[addr[7:3]] : shadow_w0[addr[7:3]];
endfunction

function automatic logic [31:0] pack_w0(input logic kon, input logic [1:0] ks,
                                        input logic [4:0] kcode, input logic [4:0] ar);
    return {19'd0, kon, ks, kcode, ar};
endfunction

function automatic logic [31:0] pack_w1(input logic [4:0] d1r, input logic [4:0] d2r,
                                        input logic [3:0] rr, input logic [3:0] d1l,
                                        input logic [6:0] tl, input logic [1:0] ams);
    return {5'd0, d1r, d2r, rr, d1l, tl, ams};
endfunction

////////////////////
// output rule

// lfa by ams, clip, tl x 8, clip, d5 wins
function automatic logic [9:0] post_atten(input logic [9:0] lvl, input logic [6:0] tl,
                                          input logic [1:0] ams, input logic [7:0] lfa,
                                          input logic d5);
    int sum;
    sum = int'(lvl);
    if (ams != 2'd0) begin
        sum = sum + (int'(lfa) << (ams - 1));
    end
    if (sum > 1023) sum = 1023;
    sum = sum + int'(tl) * 8;
    if (sum > 1023) sum = 1023;
    return d5 ? 10'd0 : sum[9:0];
endfunction

function automatic logic [9:0] exp_atten(input int s, input logic [9:0] lvl);
    return post_atten(lvl, shadow_w1[s][8:2], shadow_w1[s][1:0],
                      shadow_glob[9:2], shadow_glob[0]);
endfunction

`endif

//--- eg_tb.sv
`include "eg_settings.svh"

module eg_tb import eg_pkg::*; ();

localparam int TIMEOUT = 20000;   // cycles allowed per wait

logic                   i_EMUCLK;
logic                   mrst_n;
apb_req_t               apb_req;
apb_rsp_t               apb_rsp;
eg_out_t                eg_out;
int                     val_errs;
int                     other_errs;
int                     seen_cnt   [`EG_NUM_SLOTS];   // outputs seen per slot
int                     prst_cnt   [`EG_NUM_SLOTS];   // phase resets seen
logic [9:0]             last_atten [`EG_NUM_SLOTS];
logic [9:0]             rise_prev  [`EG_NUM_SLOTS];
logic                   rise_done  [`EG_NUM_SLOTS];
logic                   track_rise;                   // release watch on
logic [31:0]            kon_set;                      // slots keyed on

`include "eg_tb_model.svh"

initial begin
    i_EMUCLK = 1'b0;
    forever #5 i_EMUCLK = ~i_EMUCLK;
end

eg_top u_eg_top (
    .i_EMUCLK (i_EMUCLK),
    .i_mrst_n (mrst_n),
    .i_apb    (apb_req),
    .o_apb    (apb_rsp),
    .o_eg_out (eg_out)
);

////////////////////
// report helpers

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        val_errs++;
        $display("** Error: %s = %h, expected %h", name, got, exp);
    end
endtask

task automatic close_run();
    $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
        $display("TEST PASS");
    end else begin
        $display("TEST FAIL");
    end
    $finish;
endtask

task automatic report_timeout(input string what);
    other_errs++;
    $display("timeout while waiting for %s", what);
    close_run();
endtask

////////////////////
// apb driver

task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic err);
    int cycles;
    cycles = 0;
    @(posedge i_EMUCLK);
    apb_req.psel    <= 1'b1;       // setup phase
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge i_EMUCLK);
    apb_req.penable <= 1'b1;       // access phase
    @(negedge i_EMUCLK);
    while (!apb_rsp.pready && cycles < TIMEOUT) begin
        @(negedge i_EMUCLK);
        cycles++;
    end
    if (!apb_rsp.pready) report_timeout("pready");
    rdata = apb_rsp.prdata;        // sampled mid cycle
    err   = apb_rsp.pslverr;
    @(posedge i_EMUCLK);
    apb_req <= '0;
endtask

task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_val($sformatf("pslverr (write %h)", addr), err, !addr_in_map(addr));
    shadow_store(addr, data);
endtask

task automatic apb_read_check(input logic [11:0] addr);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, 32'd0, rd, err);
    check_val($sformatf("pslverr (read %h)", addr), err, !addr_in_map(addr));
    if (addr_in_map(addr)) begin
        check_val($sformatf("prdata (read %h)", addr), rd, shadow_read(addr));
    end
endtask

////////////////////
// output stream

always @(negedge i_EMUCLK) begin
    if (mrst_n === 1'b1 && !$isunknown(eg_out)) begin
        seen_cnt[eg_out.slot]   = seen_cnt[eg_out.slot] + 1;
        last_atten[eg_out.slot] = eg_out.atten;
        if (eg_out.phase_rst) begin
            prst_cnt[eg_out.slot] = prst_cnt[eg_out.slot] + 1;
        end
        if (track_rise && !rise_done[eg_out.slot]) begin
            if (eg_out.atten < rise_prev[eg_out.slot]) begin
                other_errs++;
                $display("slot %0d level fell from %h to %h during release",
                         eg_out.slot, rise_prev[eg_out.slot], eg_out.atten);
            end
            rise_prev[eg_out.slot] = eg_out.atten;
            rise_done[eg_out.slot] = (eg_out.atten >= `EG_ATTEN_NEAR_MAX);
        end
    end
end

// every slot shows n more outputs
task automatic wait_visits(input int n);
    int start [`EG_NUM_SLOTS];
    int cycles;
    int left;
    cycles = 0;
    for (int i = 0; i < `EG_NUM_SLOTS; i++) begin
        start[i] = seen_cnt[i];
    end
    do begin
        @(posedge i_EMUCLK);
        cycles++;
        left = 0;
        for (int i = 0; i < `EG_NUM_SLOTS; i++) begin
            if (seen_cnt[i] < start[i] + n) left++;
        end
    end while (left != 0 && cycles < TIMEOUT);
    if (left != 0) report_timeout("slot outputs");
endtask

task automatic wait_release_done();
    int cycles;
    int left;
    cycles = 0;
    do begin
        @(posedge i_EMUCLK);
        cycles++;
        left = 0;
        for (int i = 0; i < `EG_NUM_SLOTS; i++) begin
            if (!rise_done[i]) left++;
        end
    end while (left != 0 && cycles < TIMEOUT);
    if (left != 0) report_timeout("release to reach the top level");
endtask

////////////////////
// main sequence

initial begin
    logic [11:0] addr;
    void'($urandom(32'hff19_1716));   // seeds the run
    mrst_n     = 1'b0;
    apb_req    = '0;
    val_errs   = 0;
    other_errs = 0;
    track_rise = 1'b0;
    kon_set    = '0;
    shadow_glob = '0;
    for (int s = 0; s < `EG_NUM_SLOTS; s++) begin
        seen_cnt[s]  = 0;
        prst_cnt[s]  = 0;
        shadow_w0[s] = '0;   // bank clears at reset
        shadow_w1[s] = '0;
        rise_done[s] = 1'b0;
    end
    repeat (3) @(posedge i_EMUCLK);
    mrst_n <= 1'b1;

    // idle bank after reset
    wait_visits(2);
    for (int s = 0; s < `EG_NUM_SLOTS; s++) begin
        check_val($sformatf("o_eg_out.atten[%0d]", s), last_atten[s], exp_atten(s, 10'd1023));
        check_val($sformatf("o_eg_out.phase_rst count[%0d]", s), prst_cnt[s], 0);
    end

    // register write and read back
    for (int n = 0; n < 40; n++) begin
        addr = (n % 8 == 7) ? `EG_GLOBAL_ADDR : {4'h0, 5'($urandom), 1'($urandom), 2'b00};
        apb_write(addr, $urandom);
        apb_read_check(addr);
    end
    apb_write(12'h104, $urandom);   // holes in the map
    apb_read_check(12'h104);
    apb_read_check(12'h200);
    apb_read_check(12'h0a2);
    apb_read_check(12'hffc);

    // key on with full rate attack
    apb_write(`EG_GLOBAL_ADDR, {22'd0, 8'($urandom), 2'b00});
    for (int s = 0; s < `EG_NUM_SLOTS; s++) begin
        apb_write(12'(8 * s), 32'd0);
        apb_write(12'(8 * s + 4), pack_w1(5'd0, 5'd0, 4'($urandom), 4'($urandom),
                                          7'($urandom), 2'($urandom)));
    end
    wait_visits(2);                 // kon history all clear
    for (int s = 0; s < `EG_NUM_SLOTS; s++) begin
        prst_cnt[s] = 0;
    end
    kon_set = $urandom | 32'd1;
    for (int s = 0; s < `EG_NUM_SLOTS; s++) begin
        if (kon_set[s]) apb_write(12'(8 * s), pack_w0(1'b1, 2'($urandom), 5'($urandom), 5'd31));
    end
    wait_visits(3);
    for (int s = 0; s < `EG_NUM_SLOTS; s++) begin
        check_val($sformatf("o_eg_out.phase_rst count[%0d]", s), prst_cnt[s], kon_set[s]);
        if (kon_set[s]) begin
            check_val($sformatf("o_eg_out.atten[%0d]", s), last_atten[s], exp_atten(s, 10'd0));
        end
    end

    // test bit d5 forces zero
    apb_write(`EG_GLOBAL_ADDR, shadow_glob | 32'h1);
    wait_visits(2);
    for (int s = 0; s < `EG_NUM_SLOTS; s++) begin
        check_val($sformatf("o_eg_out.atten[%0d]", s), last_atten[s], exp_atten(s, 10'd0));
    end
    apb_write(`EG_GLOBAL_ADDR, shadow_glob & ~32'h1);
    wait_visits(2);
    for (int s = 0; s < `EG_NUM_SLOTS; s++) begin
        if (kon_set[s]) begin
            check_val($sformatf("o_eg_out.atten[%0d]", s), last_atten[s], exp_atten(s, 10'd0));
        end
    end

    // raw level climbs after key off
    for (int s = 0; s < `EG_NUM_SLOTS; s++) begin
        apb_write(12'(8 * s + 4), pack_w1(5'd0, 5'd0, 4'd15, 4'($urandom), 7'd0, 2'd0));
    end
    apb_write(`EG_GLOBAL_ADDR, {22'd0, shadow_glob[9:2], 2'b10});   // d0 speeds it up
    for (int s = 0; s < `EG_NUM_SLOTS; s++) begin
        apb_write(12'(8 * s), shadow_w0[s] & ~32'h1000);
    end
    wait_visits(2);
    for (int s = 0; s < `EG_NUM_SLOTS; s++) begin
        rise_prev[s] = 10'd0;
        rise_done[s] = 1'b0;
    end
    track_rise = 1'b1;
    wait_release_done();
    track_rise = 1'b0;

    close_run();
end

endmodule

//--- eg_top.sv
module eg_top import eg_pkg::*; (
    input  logic     i_EMUCLK,
    input  logic     i_mrst_n,
    input  apb_req_t i_apb,
    output apb_rsp_t o_apb,
    output eg_out_t  o_eg_out
);

rate_tick_t  tick;     // slot counter and rate timing
op_param_t   param;    // fetched slot settings
glob_param_t glob;
env_state_e  state;
rate_step_t  step;
eg_out_t     level;    // raw level per slot

eg_apb_regs u_apb_regs (
    .i_EMUCLK (i_EMUCLK),
    .i_mrst_n (i_mrst_n),
    .i_apb    (i_apb),
    .o_apb    (o_apb),
    .i_slot   (tick.slot),
    .o_param  (param),
    .o_glob   (glob)
);

eg_rate_gen u_rate_gen (
    .i_EMUCLK (i_EMUCLK),
    .i_mrst_n (i_mrst_n),
    .i_glob   (glob),
    .o_tick   (tick)
);

eg_rate_calc u_rate_calc (
    .i_EMUCLK (i_EMUCLK),
    .i_tick   (tick),
    .i_param  (param),
    .i_state  (state),
    .o_step   (step)
);

eg_level_core u_level_core (
    .i_EMUCLK (i_EMUCLK),
    .i_mrst_n (i_mrst_n),
    .i_step   (step),
    .i_kon    (param.kon),
    .o_state  (state),
    .o_level  (level)
);

eg_atten_post u_atten_post (
    .i_EMUCLK (i_EMUCLK),
    .i_level  (level),
    .i_param  (param),
    .i_glob   (glob),
    .o_eg_out (o_eg_out)
);

endmodule

//--- eg_atten_post.sv
`include "eg_settings.svh"

module eg_atten_post import eg_pkg::*; (
    input  logic        i_EMUCLK,
    input  eg_out_t     i_level,    // raw level from the core
    input  op_param_t   i_param,    // fetched slot, 3 ahead of i_level
    input  glob_param_t i_glob,
    output eg_out_t     o_eg_out
);

logic [2:0][8:0] par_dly;          // {tl, ams} lined up with i_level
logic [6:0]      tl;
logic [1:0]      ams;

assign {tl, ams} = par_dly[2];

always_ff @(posedge i_EMUCLK) begin
    par_dly <= {par_dly[1:0], {i_param.tl, i_param.ams}};
end

////////////////////
// stage 1 add lfa

logic [`EG_ATTEN_W-1:0] lfa_shifted;
logic [`EG_ATTEN_W:0]   mod_sum;

always_comb begin
    case (ams)
        2'd0:    lfa_shifted = '0;                      // no am
        2'd1:    lfa_shifted = {2'b00, i_glob.lfa};
        2'd2:    lfa_shifted = {1'b0, i_glob.lfa, 1'b0};
        default: lfa_shifted = {i_glob.lfa, 2'b00};
    endcase
end

assign mod_sum = {1'b0, i_level.atten} + {1'b0, lfa_shifted};

eg_out_t    s1;
logic [6:0] s1_tl;
logic       s1_d5;

always_ff @(posedge i_EMUCLK) begin
    s1       <= i_level;
    s1.atten <= mod_sum[`EG_ATTEN_W] ? `EG_ATTEN_MAX : mod_sum[`EG_ATTEN_W-1:0];
    s1_tl    <= tl;
    s1_d5    <= i_glob.test_d5;
end

////////////////////
// stage 2 add tl and test bit

logic [`EG_ATTEN_W:0] tl_sum;

assign tl_sum = {1'b0, s1.atten} + {1'b0, s1_tl, 3'b000};   // tl x 8

always_ff @(posedge i_EMUCLK) begin
    o_eg_out       <= s1;
    if (s1_d5) begin
        o_eg_out.atten <= '0;                              // force loudest
    end else begin
        o_eg_out.atten <= tl_sum[`EG_ATTEN_W] ? `EG_ATTEN_MAX : tl_sum[`EG_ATTEN_W-1:0];
    end
end

endmodule

//--- eg_level_core.sv
`include "eg_settings.svh"

module eg_level_core import eg_pkg::*; (
    input  logic       i_EMUCLK,
    input  logic       i_mrst_n,
    input  rate_step_t i_step,
    input  logic       i_kon,       // kon of the fetched slot
    output env_state_e o_state,     // state of the fetched slot
    output eg_out_t    o_level
);

////////////////////
// key on detect at fetch

logic [`EG_NUM_SLOTS-1:0]  kon_hist;   // kon seen on the last visit
logic [`EG_SLOT_W-1:0]     fetch_slot;
logic                      kon_new;
logic [1:0]                kon_dly;    // lines up with i_step
logic [1:0]                rise_dly;

assign fetch_slot = i_step.slot + 2'd2;              // rate_calc is 2 deep
assign kon_new    = i_kon && !kon_hist[fetch_slot];

////////////////////
// state and level

env_state_e             state_mem [`EG_NUM_SLOTS];
logic [`EG_ATTEN_W-1:0] level_mem [`EG_NUM_SLOTS];
env_state_e             cur_state;
env_state_e             next_state;
logic [`EG_ATTEN_W-1:0] prev;
logic [`EG_ATTEN_W-1:0] gated;
logic [`EG_ATTEN_W-1:0] delta;
logic [3:0]             weight;
logic                   kon;
logic                   rise;
logic                   at_min;
logic                   at_max;
logic                   d1_end;
logic                   atten_inc;
logic                   atten_dec;

assign o_state = kon_new ? ATTACK : state_mem[fetch_slot];

assign kon    = kon_dly[1];
assign rise   = rise_dly[1];
assign prev   = level_mem[i_step.slot];
assign weight = i_step.egparam_zero ? 4'd0 : i_step.deltaweight;   // rate 0 holds
assign cur_state = rise ? ATTACK : state_mem[i_step.slot];

assign at_min = (prev == '0);
assign at_max = (prev >= `EG_ATTEN_NEAR_MAX);
assign d1_end = (prev[9:4] == {(i_step.d1l == 4'd15), i_step.d1l, 1'b0});   // d1l 15 maps to top

assign atten_inc = !rise && !at_max &&
                   ((cur_state == FIRST_DECAY && !d1_end) ||
                    cur_state == SECOND_DECAY || cur_state == RELEASE);
assign atten_dec = (cur_state == ATTACK) && kon && !at_min && !i_step.fullrate;

always_comb begin
    next_state = cur_state;
    if (rise) begin
        next_state = ATTACK;
    end else if (!kon) begin
        next_state = RELEASE;                       // key off
    end else begin
        case (cur_state)
            ATTACK:       if (at_min) next_state = FIRST_DECAY;
            FIRST_DECAY:  if (at_max) next_state = RELEASE;
                          else if (d1_end) next_state = SECOND_DECAY;
            SECOND_DECAY: if (at_max) next_state = RELEASE;
            default:      next_state = RELEASE;
        endcase
    end
end

// attack adds an inverted slice of the level so it falls
always_comb begin
    delta = '0;
    if (atten_inc) begin
        delta = {6'd0, weight};
    end else if (atten_dec) begin
        case (weight)
            4'b0001: delta = {4'b1111, ~prev[9:5], ~prev[3]};
            4'b0010: delta = {3'b111, ~prev[9:5], ~prev[3], ~prev[1]};
            4'b0100: delta = {2'b11, ~prev[9:5], ~prev[3], {2{~prev[2]}}};
            4'b1000: delta = {1'b1, ~prev[9:5], {4{~prev[4]}}};
            default: delta = '0;
        endcase
    end
end

always_comb begin
    if (cur_state != ATTACK && !rise && at_max) begin
        gated = `EG_ATTEN_MAX;                      // pin quiet slots
    end else if (rise && i_step.fullrate) begin
        gated = '0;                                 // full rate attack
    end else begin
        gated = prev;
    end
end

always_ff @(posedge i_EMUCLK) begin
    if (!i_mrst_n) begin
        for (int i = 0; i < `EG_NUM_SLOTS; i++) begin
            state_mem[i] <= RELEASE;
            level_mem[i] <= `EG_ATTEN_MAX;
        end
        kon_hist <= '0;
        kon_dly  <= '0;
        rise_dly <= '0;
        o_level  <= '{slot: '0, atten: `EG_ATTEN_MAX, phase_rst: 1'b0};
    end else begin
        kon_hist[fetch_slot] <= i_kon;
        kon_dly  <= {kon_dly[0], i_kon};
        rise_dly <= {rise_dly[0], kon_new};
        state_mem[i_step.slot] <= next_state;
        level_mem[i_step.slot] <= gated + delta;    // carry dropped
        o_level <= '{slot: i_step.slot, atten: gated + delta, phase_rst: rise};
    end
end

endmodule

//--- eg_rate_calc.sv
module eg_rate_calc import eg_pkg::*; (
    input  logic       i_EMUCLK,
    input  rate_tick_t i_tick,
    input  op_param_t  i_param,
    input  env_state_e i_state,    // state of the fetched slot
    output rate_step_t o_step
);

////////////////////
// stage 1 rate select

logic [4:0] egparam;
logic [4:0] keyscale;

always_comb begin
    case (i_state)
        ATTACK:       egparam = i_param.ar;
        FIRST_DECAY:  egparam = i_param.d1r;
        SECOND_DECAY: egparam = i_param.d2r;
        default:      egparam = {i_param.rr, 1'b1};   // release, 4 bit rate
    endcase
end

// key scale from the key code
always_comb begin
    case (i_param.ks)
        2'd0:    keyscale = (egparam == 5'd0) ? 5'd0 : {3'b000, i_param.kcode[4:3]};
        2'd1:    keyscale = {2'b00, i_param.kcode[4:2]};
        2'd2:    keyscale = {1'b0, i_param.kcode[4:1]};
        default: keyscale = i_param.kcode;
    endcase
end

logic [4:0] s1_egparam;
logic       s1_zero;
logic [4:0] s1_keyscale;
logic [3:0] s1_d1l;
rate_tick_t s1_tick;

always_ff @(posedge i_EMUCLK) begin
    s1_egparam  <= egparam;
    s1_zero     <= (egparam == 5'd0);
    s1_keyscale <= keyscale;
    s1_d1l      <= i_param.d1l;
    s1_tick     <= i_tick;
end

////////////////////
// stage 2 delta weight

logic [6:0] scaled_sum;
logic [5:0] scaled;
logic [5:0] rateapplied;
logic       intensity;     // 1 strong, 0 weak
logic [3:0] weight;

assign scaled_sum  = {1'b0, s1_egparam, 1'b0} + {2'b00, s1_keyscale};   // 2 x rate + ks
assign scaled      = scaled_sum[6] ? 6'd63 : scaled_sum[5:0];           // saturate
assign rateapplied = scaled + {s1_tick.attenrate, 2'b00};               // carry dropped

// intensity table
always_comb begin
    case (scaled[1:0])
        2'd0:    intensity = 1'b0;
        2'd1:    intensity = (s1_tick.envcntr == 2'd0);
        2'd2:    intensity = ~s1_tick.envcntr[0];
        default: intensity = (s1_tick.envcntr != 2'd3);
    endcase
end

always_comb begin
    weight = 4'b0000;
    if (s1_tick.third_sample) begin   // level moves on third samples only
        case (scaled[5:2])
            4'b1111: weight = 4'b1000;
            4'b1110: weight = intensity ? 4'b1000 : 4'b0100;
            4'b1101: weight = intensity ? 4'b0100 : 4'b0010;
            4'b1100: weight = intensity ? 4'b0010 : 4'b0001;
            default: begin
                // slow rates step when the rate lands on a set of slots
                if ((scaled != 6'd0) &&
                    (rateapplied inside {6'd48, 6'd49, 6'd50, 6'd51,
                                         6'd54, 6'd55, 6'd57, 6'd59})) begin
                    weight = 4'b0001;
                end
            end
        endcase
    end
end

always_ff @(posedge i_EMUCLK) begin
    o_step <= '{
        slot:         s1_tick.slot,
        deltaweight:  weight,
        fullrate:     (scaled[5:1] == 5'b11111),   // 62 or 63
        d1l:          s1_d1l,
        egparam_zero: s1_zero
    };
end

endmodule

//--- eg_rate_gen.sv
`include "eg_settings.svh"

module eg_rate_gen import eg_pkg::*; (
    input  logic        i_EMUCLK,
    input  logic        i_mrst_n,
    input  glob_param_t i_glob,
    output rate_tick_t  o_tick
);

logic [`EG_SLOT_W-1:0]     slot_cnt;
logic [1:0]                sample_cnt;   // counts 0 to 2
logic                      third_sample;
logic [`EG_TIMECNTR_W-1:0] time_cnt;
logic [`EG_TIMECNTR_W-1:0] time_nxt;
logic [1:0]                envcntr;
logic [3:0]                attenrate;

// trailing zeros plus one, 0 for an empty counter
function automatic logic [3:0] rate_of(input logic [`EG_TIMECNTR_W-1:0] cnt);
    logic [3:0] r;
    r = 4'd0;
    for (int i = `EG_TIMECNTR_W - 1; i >= 0; i--) begin
        if (cnt[i]) begin
            r = (i > 13) ? 4'd14 : 4'(i + 1);   // lowest set bit wins, max 14
        end
    end
    return r;
endfunction

assign third_sample = (sample_cnt == 2'd2) || i_glob.test_d0;
assign time_nxt     = time_cnt + 1'b1;

always_ff @(posedge i_EMUCLK) begin
    if (!i_mrst_n) begin
        slot_cnt   <= '0;
        sample_cnt <= '0;
        time_cnt   <= '0;
        envcntr    <= '0;
        attenrate  <= '0;
    end else begin
        slot_cnt <= slot_cnt + 1'b1;   // one slot per clock
        if (&slot_cnt) begin           // end of sample
            sample_cnt <= (sample_cnt == 2'd2) ? 2'd0 : sample_cnt + 1'b1;
            if (third_sample) begin
                time_cnt  <= time_nxt;
                envcntr   <= time_nxt[2:1];
                attenrate <= rate_of(time_nxt);   // held for the next sample
            end
        end
    end
end

assign o_tick = '{
    slot:         slot_cnt,
    third_sample: third_sample,
    envcntr:      envcntr,
    attenrate:    attenrate
};

endmodule

//--- eg_apb_regs.sv
`include "eg_settings.svh"

module eg_apb_regs import eg_pkg::*; (
    input  logic                  i_EMUCLK,
    input  logic                  i_mrst_n,
    input  apb_req_t              i_apb,
    output apb_rsp_t              o_apb,
    input  logic [`EG_SLOT_W-1:0] i_slot,     // slot now being fetched
    output op_param_t             o_param,
    output glob_param_t           o_glob
);

////////////////////
// register map
//
// slot word 0 at 8s
//   [12] kon  [11:10] ks  [9:5] kcode  [4:0] ar
// slot word 1 at 8s+4
//   [26:22] d1r  [21:17] d2r  [16:13] rr  [12:9] d1l  [8:2] tl  [1:0] ams
// global word at 0x100
//   [9:2] lfa  [1] test_d0  [0] test_d5

op_param_t             bank [`EG_NUM_SLOTS];   // one entry per slot
glob_param_t           glob;
op_param_t             rd_param;
logic [31:0]           rdata;
logic [`EG_SLOT_W-1:0] addr_slot;
logic                  addr_word;              // 0 rates, 1 levels
logic                  slot_hit;
logic                  glob_hit;
logic                  access;

assign addr_slot = i_apb.paddr[7:3];
assign addr_word = i_apb.paddr[2];
assign slot_hit  = (i_apb.paddr[11:8] == 4'h0) && (i_apb.paddr[1:0] == 2'b00);
assign glob_hit  = (i_apb.paddr == `EG_GLOBAL_ADDR);
assign access    = i_apb.psel && i_apb.penable;   // access phase
assign rd_param  = bank[addr_slot];

// writes land at the access phase edge
always_ff @(posedge i_EMUCLK) begin
    if (!i_mrst_n) begin
        for (int i = 0; i < `EG_NUM_SLOTS; i++) begin
            bank[i] <= '0;
        end
        glob <= '0;
    end else if (access && i_apb.pwrite) begin
        if (slot_hit && !addr_word) begin
            {bank[addr_slot].kon, bank[addr_slot].ks, bank[addr_slot].kcode,
             bank[addr_slot].ar} <= i_apb.pwdata[12:0];
        end else if (slot_hit) begin
            {bank[addr_slot].d1r, bank[addr_slot].d2r, bank[addr_slot].rr,
             bank[addr_slot].d1l, bank[addr_slot].tl,
             bank[addr_slot].ams} <= i_apb.pwdata[26:0];
        end else if (glob_hit) begin
            glob <= i_apb.pwdata[9:0];
        end
    end
end

// read back the stored bits
always_comb begin
    rdata = '0;
    if (slot_hit && !addr_word) begin
        rdata[12:0] = {rd_param.kon, rd_param.ks, rd_param.kcode, rd_param.ar};
    end else if (slot_hit) begin
        rdata[26:0] = {rd_param.d1r, rd_param.d2r, rd_param.rr,
                       rd_param.d1l, rd_param.tl, rd_param.ams};
    end else if (glob_hit) begin
        rdata[9:0] = glob;
    end
end

assign o_apb = '{
    prdata:  rdata,
    pready:  1'b1,                                 // no wait states
    pslverr: access && !(slot_hit || glob_hit)     // hole in the map
};

assign o_param = bank[i_slot];   // combinational fetch
assign o_glob  = glob;

endmodule

//--- eg_pkg.sv
`include "eg_settings.svh"

package eg_pkg;

    // envelope phase of one slot
    typedef enum logic [1:0] {
        ATTACK,
        FIRST_DECAY,
        SECOND_DECAY,
        RELEASE
    } env_state_e;

    // settings of one operator slot
    typedef struct packed {
        logic       kon;    // key on
        logic [1:0] ks;     // key scale
        logic [4:0] kcode;  // key code for rate scaling
        logic [4:0] ar;     // attack rate
        logic [4:0] d1r;    // first decay rate
        logic [4:0] d2r;    // second decay rate
        logic [3:0] rr;     // release rate
        logic [3:0] d1l;    // first decay level
        logic [6:0] tl;     // total level
        logic [1:0] ams;    // am sensitivity
    } op_param_t;

    typedef struct packed {
        logic [7:0] lfa;    // am depth from the lfo
        logic       test_d0;
        logic       test_d5;
    } glob_param_t;

    // apb driver to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [`EG_SLOT_W-1:0] slot;
        logic                  third_sample;
        logic [1:0]            envcntr;
        logic [3:0]            attenrate;
    } rate_tick_t;

    typedef struct packed {
        logic [`EG_SLOT_W-1:0] slot;
        logic [3:0]            deltaweight;
        logic                  fullrate;
        logic [3:0]            d1l;
        logic                  egparam_zero;
    } rate_step_t;

    typedef struct packed {
        logic [`EG_SLOT_W-1:0]  slot;
        logic [`EG_ATTEN_W-1:0] atten;
        logic                   phase_rst;
    } eg_out_t;

endpackage

//--- eg_settings.svh
`ifndef EG_SETTINGS_SVH
`define EG_SETTINGS_SVH

////////////////////
// slot multiplex

`define EG_NUM_SLOTS        32          // operator slots served in turn
`define EG_SLOT_W           5           // slot index width

////////////////////
// attenuation level

`define EG_ATTEN_W          10          // level 0 is the loudest
`define EG_ATTEN_MAX        10'd1023    // quietest level
`define EG_ATTEN_NEAR_MAX   10'd1008    // decay stops from here on

////////////////////
// rate generator and bus

`define EG_TIMECNTR_W       15          // attenuation rate time counter
`define EG_GLOBAL_ADDR      12'h100     // lfa and test bits

`endif
